/* include/pulse_tx_settings.svh */
`ifndef PULSE_TX_SETTINGS_SVH
`define PULSE_TX_SETTINGS_SVH

// Peripheral bus and program store
`define PULSE_DATA_W      32
`define PULSE_ADDR_W      6
`define PULSE_MEM_WORDS   8
`define PULSE_MEM_AW      $clog2(`PULSE_MEM_WORDS)

// Sequencer and timer widths
`define PULSE_PC_W        8
`define PULSE_LOOP_W      8
`define PULSE_DUR_W       8
`define PULSE_PRESC_W     4
`define PULSE_CARRIER_W   16
`define PULSE_IRQ_W       3

// Write size codes on data_write_n, 2'b11 means no write
`define PULSE_WR_8        2'b00
`define PULSE_WR_32       2'b10

// Register word offsets, address bits 4:2
`define PULSE_REG_CTRL    3'd0
`define PULSE_REG_PROG    3'd1
`define PULSE_REG_DUR     3'd2
`define PULSE_REG_PRESC   3'd3
`define PULSE_REG_CARRIER 3'd4
`define PULSE_REG_SYM     3'd5

// Address bit that selects program memory
`define PULSE_MEM_SEL_BIT 5

// Control word fields
`define PULSE_CTRL_RUN_BIT     4
`define PULSE_CTRL_STOP_BIT    5
`define PULSE_CTRL_MASK_LSB    8
`define PULSE_CTRL_FOREVER_BIT 12
`define PULSE_CTRL_IDLE_BIT    13
`define PULSE_CTRL_INVERT_BIT  14
`define PULSE_CTRL_CARRIER_BIT 15
`define PULSE_CTRL_MODE_BIT    17

// Main prescaler sits in the top nibble of its register
`define PULSE_PRESC_LSB   28

`endif

/* hw/pulse_tx_pkg.sv */
`include "pulse_tx_settings.svh"

package pulse_tx_pkg;

    // Bits per program element
    typedef enum logic {
        MODE_1BPE = 1'b0,
        MODE_2BPE = 1'b1
    } pulse_mode_t;

    // Register word index within the register half of the map
    typedef enum logic [2:0] {
        REG_CTRL    = `PULSE_REG_CTRL,
        REG_PROG    = `PULSE_REG_PROG,
        REG_DUR     = `PULSE_REG_DUR,
        REG_PRESC   = `PULSE_REG_PRESC,
        REG_CARRIER = `PULSE_REG_CARRIER,
        REG_SYM     = `PULSE_REG_SYM
    } pulse_reg_t;

    // Decoded configuration seen by the datapath
    typedef struct packed {
        pulse_mode_t                 mode;
        logic                        loop_forever;
        logic                        idle_level;
        logic                        invert;
        logic                        carrier_en;
        logic [`PULSE_IRQ_W-1:0]     irq_mask;
        logic [`PULSE_PC_W-1:0]      start_index;
        logic [`PULSE_PC_W-1:0]      end_index;
        logic [`PULSE_PC_W-1:0]      loopback_index;
        logic [`PULSE_LOOP_W-1:0]    loop_count;
        logic [`PULSE_DUR_W-1:0]     low_dur_a;
        logic [`PULSE_DUR_W-1:0]     low_dur_b;
        logic [`PULSE_DUR_W-1:0]     high_dur_a;
        logic [`PULSE_DUR_W-1:0]     high_dur_b;
        logic [`PULSE_PRESC_W-1:0]   prescaler;
        logic [`PULSE_CARRIER_W-1:0] carrier_half;
        logic [1:0]                  low_sym_0;
        logic [1:0]                  low_sym_1;
        logic [1:0]                  high_sym_0;
        logic [1:0]                  high_sym_1;
    } pulse_cfg_t;

    // Event pulses, timer_tick lands on bit 0 like the status field
    typedef struct packed {
        logic ended;
        logic looped;
        logic timer_tick;
    } pulse_evt_t;

endpackage

/* hw/pulse_cfg_if.sv */
`timescale 1ns/1ps
`include "pulse_tx_settings.svh"

interface pulse_cfg_if
    import pulse_tx_pkg::*;
();

    // Configuration and run flag from the register block
    pulse_cfg_t cfg;
    logic       running;

    // Event pulses from the sequencer
    pulse_evt_t evt;

    // Sequencer state for readback
    logic [`PULSE_PC_W-1:0]   pc;
    logic [`PULSE_LOOP_W-1:0] loop_left;

    modport regs (
        output cfg,
        output running,
        input  evt,
        input  pc,
        input  loop_left
    );

    modport seq (
        input  cfg,
        input  running,
        output evt,
        output pc,
        output loop_left
    );

endinterface

/* hw/pulse_tx_regs.sv */
`timescale 1ns/1ps
`include "pulse_tx_settings.svh"

module pulse_tx_regs
    import pulse_tx_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`PULSE_ADDR_W-1:0]  address,
    input  logic [`PULSE_DATA_W-1:0]  data_in,
    input  logic [1:0]                data_write_n,
    output logic [`PULSE_DATA_W-1:0]  data_out,
    output logic                      user_interrupt,
    pulse_cfg_if.regs                 cfg_bus,
    output logic                      mem_we,
    output logic [`PULSE_MEM_AW-1:0]  mem_addr,
    output logic [`PULSE_DATA_W-1:0]  mem_wdata
);

    pulse_cfg_t              cfg;
    logic                    running;
    logic [`PULSE_IRQ_W-1:0] status;
    logic [`PULSE_IRQ_W-1:0] evt_bits;
    logic                    wr_word;
    logic                    wr_any;
    logic                    mem_sel;
    pulse_reg_t              reg_idx;

    // Write size decode
    assign wr_word = (data_write_n == `PULSE_WR_32);
    assign wr_any  = wr_word || (data_write_n == `PULSE_WR_8);

    // Upper half of the map is program memory
    assign mem_sel = address[`PULSE_MEM_SEL_BIT];
    assign reg_idx = pulse_reg_t'(address[`PULSE_MEM_SEL_BIT-1:2]);

    // Only full word writes reach the program store
    assign mem_we    = wr_word && mem_sel;
    assign mem_addr  = address[`PULSE_MEM_AW+1:2];
    assign mem_wdata = data_in;

    // Events that are allowed to latch
    assign evt_bits = cfg_bus.evt & cfg.irq_mask;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg     <= '0;
            running <= 1'b0;
            status  <= '0;
        end else begin
            // Events latch, a finished program drops the run flag
            status  <= status | evt_bits;
            running <= running && !cfg_bus.evt.ended;

            if (wr_any && !mem_sel) begin
                case (reg_idx)
                    REG_CTRL: begin
                        // Ones in the low bits clear status
                        status <= (status & ~data_in[`PULSE_IRQ_W-1:0]) | evt_bits;
                        // Stop wins over start
                        if (data_in[`PULSE_CTRL_STOP_BIT]) begin
                            running <= 1'b0;
                        end else if (data_in[`PULSE_CTRL_RUN_BIT]) begin
                            running <= 1'b1;
                        end
                        // Mode bits only with a full word
                        if (wr_word) begin
                            cfg.irq_mask     <= data_in[`PULSE_CTRL_MASK_LSB +: `PULSE_IRQ_W];
                            cfg.loop_forever <= data_in[`PULSE_CTRL_FOREVER_BIT];
                            cfg.idle_level   <= data_in[`PULSE_CTRL_IDLE_BIT];
                            cfg.invert       <= data_in[`PULSE_CTRL_INVERT_BIT];
                            cfg.carrier_en   <= data_in[`PULSE_CTRL_CARRIER_BIT];
                            cfg.mode         <= pulse_mode_t'(data_in[`PULSE_CTRL_MODE_BIT]);
                        end
                    end
                    REG_PROG: begin
                        // Start, end, loopback, loop count, one byte each
                        cfg.start_index    <= data_in[0 +: `PULSE_PC_W];
                        cfg.end_index      <= data_in[8 +: `PULSE_PC_W];
                        cfg.loopback_index <= data_in[16 +: `PULSE_PC_W];
                        cfg.loop_count     <= data_in[24 +: `PULSE_LOOP_W];
                    end
                    REG_DUR: begin
                        cfg.low_dur_a  <= data_in[0 +: `PULSE_DUR_W];
                        cfg.low_dur_b  <= data_in[8 +: `PULSE_DUR_W];
                        cfg.high_dur_a <= data_in[16 +: `PULSE_DUR_W];
                        cfg.high_dur_b <= data_in[24 +: `PULSE_DUR_W];
                    end
                    REG_PRESC: begin
                        cfg.prescaler <= data_in[`PULSE_PRESC_LSB +: `PULSE_PRESC_W];
                    end
                    REG_CARRIER: begin
                        cfg.carrier_half <= data_in[0 +: `PULSE_CARRIER_W];
                    end
                    REG_SYM: begin
                        // Symbols used in one-bit mode
                        cfg.low_sym_0  <= data_in[1:0];
                        cfg.low_sym_1  <= data_in[3:2];
                        cfg.high_sym_0 <= data_in[5:4];
                        cfg.high_sym_1 <= data_in[7:6];
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    assign cfg_bus.cfg     = cfg;
    assign cfg_bus.running = running;

    assign user_interrupt = |status;

    // Same word for every read address
    assign data_out = {8'h00, cfg_bus.pc, cfg_bus.loop_left, 3'b000, running, 1'b0, status};

endmodule

/* hw/symbol_mem.sv */
`timescale 1ns/1ps
`include "pulse_tx_settings.svh"

module symbol_mem (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     we,
    input  logic [`PULSE_MEM_AW-1:0] waddr,
    input  logic [`PULSE_DATA_W-1:0] wdata,
    input  logic [`PULSE_MEM_AW-1:0] raddr,
    output logic [`PULSE_DATA_W-1:0] rdata
);

    logic [`PULSE_DATA_W-1:0] mem [`PULSE_MEM_WORDS];
    logic                     we_q;
    logic [`PULSE_MEM_AW-1:0] waddr_q;
    logic [`PULSE_DATA_W-1:0] wdata_q;

    // Write strobe delayed by one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            we_q <= 1'b0;
        end else begin
            we_q <= we;
        end
    end

    // Capture stage
    always_ff @(posedge clk) begin
        if (we) begin
            waddr_q <= waddr;
            wdata_q <= wdata;
        end
    end

    // Store one edge after capture
    always_ff @(posedge clk) begin
        if (we_q) begin
            mem[waddr_q] <= wdata_q;
        end
    end

    assign rdata = mem[raddr];

endmodule

/* hw/pulse_sequencer.sv */
`timescale 1ns/1ps
`include "pulse_tx_settings.svh"

module pulse_sequencer
    import pulse_tx_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    pulse_cfg_if.seq                 cfg_bus,
    output logic [`PULSE_MEM_AW-1:0] mem_raddr,
    input  logic [`PULSE_DATA_W-1:0] mem_rdata,
    output logic                     level,
    output logic                     valid
);

    // Prescaler counter covers up to 2^15 cycles per duration step
    localparam int PS_W  = (1 << `PULSE_PRESC_W) - 1;
    localparam int BIT_W = $clog2(`PULSE_DATA_W);
    // Start-up phases, load happens in the second fetch cycle
    localparam logic [1:0] WARM_LOAD = 2'd1;
    localparam logic [1:0] WARM_RUN  = 2'd2;
    localparam logic [`PULSE_PC_W-1:0] PC_STEP_1 = 1;
    localparam logic [`PULSE_PC_W-1:0] PC_STEP_2 = 2;

    pulse_cfg_t               cfg;
    logic                     running;
    logic [`PULSE_PC_W-1:0]   pc;
    logic [`PULSE_LOOP_W-1:0] loop_left;
    logic                     half;
    logic                     eof;
    logic                     looped;
    logic [1:0]               warm;
    logic [1:0]               sym_raw;
    logic [1:0]               sym;
    logic                     sym_bit;
    logic [`PULSE_DUR_W-1:0]  sym_dur;
    logic [`PULSE_DUR_W-1:0]  dur_cnt;
    logic [PS_W-1:0]          ps_cnt;
    logic [PS_W-1:0]          ps_reload;
    logic                     last_elem;
    logic                     expiry;
    logic                     step;

    assign cfg     = cfg_bus.cfg;
    assign running = cfg_bus.running;

    // Word select from the upper pc bits
    assign mem_raddr = pc[`PULSE_PC_W-1:BIT_W];

    // Symbol decode from the fetched word
    always_comb begin
        sym_raw = mem_rdata[{pc[BIT_W-1:1], 1'b0} +: 2];
        sym_bit = mem_rdata[pc[BIT_W-1:0]];
        if (cfg.mode == MODE_2BPE) begin
            sym = sym_raw;
        end else if (sym_bit) begin
            // One data bit gives symbol_0 then symbol_1
            sym = half ? cfg.high_sym_1 : cfg.high_sym_0;
        end else begin
            sym = half ? cfg.low_sym_1 : cfg.low_sym_0;
        end
        case (sym)
            2'd0:    sym_dur = cfg.low_dur_a;
            2'd1:    sym_dur = cfg.low_dur_b;
            2'd2:    sym_dur = cfg.high_dur_a;
            default: sym_dur = cfg.high_dur_b;
        endcase
    end

    // 2^prescaler - 1
    assign ps_reload = ~({PS_W{1'b1}} << cfg.prescaler);

    assign valid  = running && (warm == WARM_RUN);
    assign expiry = valid && (ps_cnt == '0) && (dur_cnt == '0);
    // First load after fetch, then one load per expiry
    assign step   = (running && (warm == WARM_LOAD)) || expiry;

    // Element finished once both halves are out in one-bit mode
    assign last_elem = (cfg.mode == MODE_2BPE) || half;

    // Program counter and loop control
    always_ff @(posedge clk) begin
        if (!rst_n || !running) begin
            pc        <= cfg.start_index;
            loop_left <= cfg.loop_count;
            half      <= 1'b0;
            eof       <= 1'b0;
            looped    <= 1'b0;
            warm      <= '0;
        end else begin
            looped <= 1'b0;
            if (warm != WARM_RUN) begin
                warm <= warm + 2'd1;
            end
            // pc moves as a symbol loads, so the next word is read ahead
            if (step) begin
                half <= !last_elem;
                if (last_elem) begin
                    if (pc == cfg.end_index) begin
                        if (!cfg.loop_forever && (loop_left == '0)) begin
                            // Last symbol loaded, finish on its expiry
                            eof <= 1'b1;
                        end else begin
                            pc        <= cfg.loopback_index;
                            loop_left <= loop_left - 1'b1;
                            looped    <= 1'b1;
                        end
                    end else begin
                        pc <= pc + ((cfg.mode == MODE_2BPE) ? PC_STEP_2 : PC_STEP_1);
                    end
                end
            end
        end
    end

    // Symbol countdown, (dur + 1) * 2^prescaler cycles
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dur_cnt <= '0;
            ps_cnt  <= '0;
            level   <= 1'b0;
        end else if (step) begin
            dur_cnt <= sym_dur;
            ps_cnt  <= ps_reload;
            // Upper symbol bit is the line level
            level   <= sym[1];
        end else if (valid) begin
            if (ps_cnt == '0) begin
                dur_cnt <= dur_cnt - 1'b1;
                ps_cnt  <= ps_reload;
            end else begin
                ps_cnt <= ps_cnt - 1'b1;
            end
        end
    end

    assign cfg_bus.evt.timer_tick = expiry;
    assign cfg_bus.evt.looped     = looped;
    assign cfg_bus.evt.ended      = expiry && eof;
    assign cfg_bus.pc             = pc;
    assign cfg_bus.loop_left      = loop_left;

endmodule

/* hw/carrier_gen.sv */
`timescale 1ns/1ps
`include "pulse_tx_settings.svh"

module carrier_gen (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        en,
    input  logic [`PULSE_CARRIER_W-1:0] half_period,
    output logic                        carrier
);

    logic [`PULSE_CARRIER_W-1:0] cnt;

    // Square wave, half_period + 1 cycles per half
    always_ff @(posedge clk) begin
        if (!rst_n || !en) begin
            // Restart low whenever disabled
            cnt     <= '0;
            carrier <= 1'b0;
        end else if (cnt == half_period) begin
            cnt     <= '0;
            carrier <= !carrier;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

/* hw/pulse_transmitter.sv */
`timescale 1ns/1ps
`include "pulse_tx_settings.svh"

module pulse_transmitter (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`PULSE_ADDR_W-1:0] address,
    input  logic [`PULSE_DATA_W-1:0] data_in,
    input  logic [1:0]               data_write_n,
    output logic [`PULSE_DATA_W-1:0] data_out,
    output logic                     data_ready,
    output logic [7:0]               uo_out,
    output logic                     user_interrupt
);

    logic                     mem_we;
    logic [`PULSE_MEM_AW-1:0] mem_addr;
    logic [`PULSE_DATA_W-1:0] mem_wdata;
    logic [`PULSE_MEM_AW-1:0] mem_raddr;
    logic [`PULSE_DATA_W-1:0] mem_rdata;
    logic                     level;
    logic                     valid;
    logic                     carrier;
    logic                     shaped;
    logic                     pin_level;

    pulse_cfg_if cfg_bus ();

    pulse_tx_regs u_regs (
        .clk            (clk),
        .rst_n          (rst_n),
        .address        (address),
        .data_in        (data_in),
        .data_write_n   (data_write_n),
        .data_out       (data_out),
        .user_interrupt (user_interrupt),
        .cfg_bus        (cfg_bus.regs),
        .mem_we         (mem_we),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata)
    );

    symbol_mem u_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (mem_we),
        .waddr (mem_addr),
        .wdata (mem_wdata),
        .raddr (mem_raddr),
        .rdata (mem_rdata)
    );

    pulse_sequencer u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_bus   (cfg_bus.seq),
        .mem_raddr (mem_raddr),
        .mem_rdata (mem_rdata),
        .level     (level),
        .valid     (valid)
    );

    // Carrier runs in step with the symbol output
    carrier_gen u_carrier (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (cfg_bus.cfg.carrier_en && valid),
        .half_period (cfg_bus.cfg.carrier_half),
        .carrier     (carrier)
    );

    // Carrier gating, idle substitution, then optional inversion
    always_comb begin
        shaped    = cfg_bus.cfg.carrier_en ? (level && carrier) : level;
        pin_level = (valid ? shaped : cfg_bus.cfg.idle_level) ^ cfg_bus.cfg.invert;
    end

    assign uo_out[1:0] = {carrier, carrier};
    assign uo_out[2]   = valid;
    assign uo_out[3]   = 1'b0;
    assign uo_out[7:4] = {4{pin_level}};

    // Reads never stall
    assign data_ready = 1'b1;

endmodule

/* tests/pulse_transmitter_assert.sv */
`timescale 1ns/1ps

module pulse_transmitter_assert (
    input logic       clk,
    input logic       rst_n,
    input logic       data_ready,
    input logic [7:0] uo_out,
    input logic       carrier_en,
    input logic       idle_level,
    input logic       invert
);

    // Bus never stalls
    a_ready_high: assert property (@(posedge clk) disable iff (!rst_n)
        data_ready)
        else $error("data_ready dropped");

    // All four pulse pins agree, idle value while not valid
    a_pins_equal: assert property (@(posedge clk) disable iff (!rst_n)
        uo_out[7:4] == {4{uo_out[2] ? uo_out[4] : (idle_level ^ invert)}})
        else $error("pulse pins wrong");

    // No output valid right after reset release
    a_idle_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !uo_out[2])
        else $error("valid high after reset");

    // Carrier pins settle low once the carrier is off
    a_carrier_pins: assert property (@(posedge clk) disable iff (!rst_n)
        !carrier_en |=> (uo_out[1:0] == 2'b00))
        else $error("carrier pins active while carrier disabled");

endmodule

bind pulse_transmitter pulse_transmitter_assert u_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .data_ready (data_ready),
    .uo_out     (uo_out),
    .carrier_en (cfg_bus.cfg.carrier_en),
    .idle_level (cfg_bus.cfg.idle_level),
    .invert     (cfg_bus.cfg.invert)
);

/* tests/pulse_transmitter_tb.sv */
`timescale 1ns/1ps
`include "pulse_tx_settings.svh"

module pulse_transmitter_tb;

    localparam int REC_WORDS = 16;
    localparam int NUM_TESTS = 5;
    localparam int TIMEOUT   = 20000;

    logic        clk;
    logic        rst_n;
    logic [5:0]  address;
    logic [31:0] data_in;
    logic [1:0]  data_write_n;
    logic [31:0] data_out;
    logic        data_ready;
    logic [7:0]  uo_out;
    logic        user_interrupt;

    logic [31:0] patterns [NUM_TESTS*REC_WORDS];
    logic [31:0] rec [REC_WORDS];
    logic        pin_q [$];
    logic        car_q [$];
    int          fails;
    int          test_fails;
    int          passed;
    int          tests_run;
    logic        aborted;
    string       name;

    pulse_transmitter UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .address        (address),
        .data_in        (data_in),
        .data_write_n   (data_write_n),
        .data_out       (data_out),
        .data_ready     (data_ready),
        .uo_out         (uo_out),
        .user_interrupt (user_interrupt)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [5:0] reg_addr(input logic [2:0] idx);
        return {1'b0, idx, 2'b00};
    endfunction

    // One-cycle write strobe
    task automatic bus_write(input logic [5:0] addr, input logic [31:0] data,
                             input logic [1:0] size);
        @(posedge clk);
        address      <= addr;
        data_in      <= data;
        data_write_n <= size;
        @(posedge clk);
        data_write_n <= 2'b11;
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (exp === act) else begin
            $display("CHECK FAILED %s: %s expected %h actual %h", name, what, exp, act);
            test_fails++;
        end
    endtask

    // Counts as a failure and ends the test sequence
    task automatic abort_run(input string what);
        $display("%s in test %s", what, name);
        test_fails++;
        aborted = 1'b1;
    endtask

    // Sampled on falling edges, away from DUT updates
    task automatic wait_valid(input logic want);
        int n;
        n = 0;
        @(negedge clk);
        while (uo_out[2] !== want && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (uo_out[2] !== want) abort_run("Timed out waiting for the valid pin");
    endtask

    task automatic configure();
        // Low bits of the control word also clear old status
        bus_write(reg_addr(`PULSE_REG_CTRL), rec[1] | 32'h7, `PULSE_WR_32);
        bus_write(reg_addr(`PULSE_REG_PROG), rec[2], `PULSE_WR_32);
        bus_write(reg_addr(`PULSE_REG_DUR), rec[3], `PULSE_WR_32);
        bus_write(reg_addr(`PULSE_REG_PRESC), rec[4], `PULSE_WR_32);
        bus_write(reg_addr(`PULSE_REG_CARRIER), rec[5], `PULSE_WR_32);
        bus_write(reg_addr(`PULSE_REG_SYM), rec[6], `PULSE_WR_32);
        bus_write(6'h20, rec[7], `PULSE_WR_32);
        bus_write(6'h24, rec[8], `PULSE_WR_32);
        // Delayed store in program memory
        repeat (2) @(posedge clk);
    endtask

    task automatic start_program();
        bus_write(reg_addr(`PULSE_REG_CTRL), rec[1] | (32'd1 << `PULSE_CTRL_RUN_BIT),
                  `PULSE_WR_32);
    endtask

    task automatic stop_program();
        bus_write(reg_addr(`PULSE_REG_CTRL), rec[1] | (32'd1 << `PULSE_CTRL_STOP_BIT),
                  `PULSE_WR_32);
    endtask

    // Record pulse pin and carrier while the output is valid
    task automatic capture_run();
        int n;
        pin_q.delete();
        car_q.delete();
        wait_valid(1'b1);
        n = 0;
        while (uo_out[2] === 1'b1 && n <= TIMEOUT) begin
            pin_q.push_back(uo_out[4]);
            car_q.push_back(uo_out[0]);
            @(negedge clk);
            n++;
        end
        if (n > TIMEOUT) abort_run("Output never returned to idle");
    endtask

    // Compress samples into runs and compare with the record
    task automatic check_runs();
        int idx;
        int len;
        idx = 0;
        len = 0;
        for (int i = 0; i < pin_q.size(); i++) begin
            len++;
            if (i == pin_q.size() - 1 || pin_q[i+1] != pin_q[i]) begin
                if (idx < rec[9]) begin
                    check_value($sformatf("run %0d", idx), rec[10+idx],
                                {15'd0, pin_q[i], len[15:0]});
                end
                idx++;
                len = 0;
            end
        end
        check_value("run count", rec[9], idx);
    endtask

    // Per cycle pin equals symbol level gated by the expected carrier
    task automatic check_carrier();
        int   k;
        int   left;
        int   total;
        int   interval;
        logic car_exp;
        interval = int'(rec[5][15:0]) + 1;
        total = 0;
        for (int j = 0; j < rec[9]; j++) begin
            total += int'(rec[10+j][15:0]);
        end
        check_value("valid cycles", total, pin_q.size());
        k = 0;
        left = int'(rec[10][15:0]);
        for (int i = 0; i < pin_q.size() && i < total; i++) begin
            // Carrier starts low on the first valid cycle
            car_exp = ((i / interval) % 2) == 1;
            check_value($sformatf("carrier at cycle %0d", i), 32'(car_exp), 32'(car_q[i]));
            check_value($sformatf("pin at cycle %0d", i), 32'(rec[10+k][16] & car_exp),
                        32'(pin_q[i]));
            left--;
            if (left == 0 && k < rec[9] - 1) begin
                k++;
                left = int'(rec[10+k][15:0]);
            end
        end
    endtask

    task automatic test_readback();
        @(negedge clk);
        check_value("data_out after reset", 32'd0, data_out);
        check_value("interrupt after reset", 32'd0, 32'(user_interrupt));
        configure();
        start_program();
        stop_program();
        // pc and loop count reload one edge after the stop
        repeat (2) @(negedge clk);
        check_value("pc readback", 32'(rec[10][7:0]), 32'(data_out[23:16]));
        check_value("loop readback", 32'(rec[11][7:0]), 32'(data_out[15:8]));
    endtask

    task automatic test_two_bit();
        configure();
        start_program();
        capture_run();
        check_runs();
        @(negedge clk);
        check_value("end status", 32'd1, 32'(data_out[2]));
        check_value("running flag", 32'd0, 32'(data_out[4]));
    endtask

    task automatic test_one_bit_loops();
        configure();
        start_program();
        capture_run();
        check_runs();
        @(negedge clk);
        check_value("loop status", 32'd1, 32'(data_out[1]));
        check_value("interrupt set", 32'd1, 32'(user_interrupt));
        bus_write(reg_addr(`PULSE_REG_CTRL), 32'h2, `PULSE_WR_8);
        @(negedge clk);
        check_value("interrupt cleared", 32'd0, 32'(user_interrupt));
    endtask

    task automatic test_carrier();
        configure();
        start_program();
        capture_run();
        check_carrier();
    endtask

    task automatic test_idle_stop();
        configure();
        @(negedge clk);
        check_value("idle pins", {28'd0, {4{rec[10][0]}}}, 32'(uo_out[7:4]));
        check_value("idle valid", 32'd0, 32'(uo_out[2]));
        check_value("spare pin", 32'd0, 32'(uo_out[3]));
        start_program();
        wait_valid(1'b1);
        stop_program();
        wait_valid(1'b0);
        check_value("pins after stop", {28'd0, {4{rec[10][0]}}}, 32'(uo_out[7:4]));
    endtask

    task automatic load_record(input int t);
        for (int i = 0; i < REC_WORDS; i++) begin
            rec[i] = patterns[t*REC_WORDS+i];
        end
        case (rec[0])
            1:       name = "reset_readback";
            2:       name = "two_bit_mode";
            3:       name = "one_bit_loops";
            4:       name = "carrier";
            5:       name = "idle_invert_stop";
            default: name = "unknown";
        endcase
    endtask

    initial begin
        rst_n        = 1'b0;
        address      = '0;
        data_in      = '0;
        data_write_n = 2'b11;
        fails        = 0;
        passed       = 0;
        tests_run    = 0;
        aborted      = 1'b0;
        $readmemh("tests/pulse_patterns.mem", patterns);
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        // A timed out wait ends the sequence early
        for (int t = 0; t < NUM_TESTS && !aborted; t++) begin
            load_record(t);
            test_fails = 0;
            case (rec[0])
                1:       test_readback();
                2:       test_two_bit();
                3:       test_one_bit_loops();
                4:       test_carrier();
                5:       test_idle_stop();
                default: abort_run("Unknown test id in pattern file");
            endcase
            $display("Test %-18s %s", name, (test_fails == 0) ? "ok" : "with errors");
            if (test_fails == 0) passed++;
            fails += test_fails;
            tests_run++;
        end
        $display("Tests run %0d, clean %0d, check failures %0d", tests_run, passed, fails);
        if (fails == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* tests/pulse_patterns.mem */
// One record per test, sixteen words each
// id ctrl prog dur presc carrier sym word0 / word1 nruns then six words of results
// A run word is {level in bit 16, length in bits 15:0}
// Test 1 puts the expected pc and loop_left in the first two result words
// Test 5 puts the expected idle pin value in the first result word

// Reset and readback
00000001 00020000 05040604 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000004 00000005 00000000 00000000 00000000 00000000

// Two-bit mode, four symbols, runs of equal level merge
00000002 00020700 00000600 04030102 10000000 00000000 00000000 000000D2
00000000 00000003 00010008 0000000A 0001000A 00000000 00000000 00000000

// One-bit mode, loopback to index 1 once
00000003 00000200 01010200 04030102 00000000 00000000 00000078 00000002
00000000 00000006 00000003 00010009 00000005 00010009 00000005 00010004

// Carrier on a high symbol then a low symbol
00000004 00028000 00000200 000B0005 00000000 00000002 00000000 00000002
00000000 00000002 0001000C 00000006 00000000 00000000 00000000 00000000

// Idle with inversion, stopped in the middle of a long program
00000005 00024000 00000200 00FF00FF 30000000 00000000 00000000 00000002
00000000 00000000 00000001 00000000 00000000 00000000 00000000 00000000

/* pulse_transmitter.f */
+incdir+include
hw/pulse_tx_pkg.sv
hw/pulse_cfg_if.sv
hw/pulse_tx_regs.sv
hw/symbol_mem.sv
hw/pulse_sequencer.sv
hw/carrier_gen.sv
hw/pulse_transmitter.sv
tests/pulse_transmitter_assert.sv
tests/pulse_transmitter_tb.sv

/* Makefile */
.PHONY: lint sim clean

LOG := sim.log

lint:
	verilator --lint-only --timing --assert -f pulse_transmitter.f \
		--top-module pulse_transmitter_tb

sim:
	verilator --binary --timing --assert -f pulse_transmitter.f \
		--top-module pulse_transmitter_tb -o pulse_sim
	./obj_dir/pulse_sim | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
